/* dv/if_stim.txt */
// Fetch stimulus as 32-bit hex words for $readmemh
// @00 header: memory base address, memory words, command count, expected count
// @10 memory image: consecutive words from the base address
// @40 commands: trigger retired count, kind (1 redirect with kill, 2 halt, 3 kill),
//     target or cycles, privilege
// @80 expected stream: pc, instruction, flags (bit 4 compressed, bits 1:0 privilege)
@00
00000080 0000001e 00000006 0000001a
@10
00100093 01130085 45010020 81930505 82130030 00010041 00520293 06094605
00a00013 00a40013 00a80013 00ac0013 00b00013 00b40013 00b80013 00bc0013
8313dead 47110062 83930785 80820073 00d00013 00d40013 00d80013 00dc0013
05914581 00b50533 05338532 000140b5 00c58593 00f40013
@40
00000004 00000002 00000006 00000000
0000000b 00000001 000000c2 00000003
0000000e 00000003 00000003 00000000
0000000e 00000001 000000e0 00000000
00000011 00000002 00000004 00000000
00000015 00000001 0000008e 00000003
@80
00000080 00100093 00000003 00000084 00000085 00000013
00000086 00200113 00000003 0000008a 00004501 00000013
0000008c 00000505 00000013 0000008e 00308193 00000003
00000092 00418213 00000003 00000096 00000001 00000013
00000098 00520293 00000003 0000009c 00004605 00000013
0000009e 00000609 00000013 000000c2 00628313 00000003
000000c6 00004711 00000013 000000c8 00000785 00000013
000000e0 00004581 00000010 000000e2 00000591 00000010
000000e4 00b50533 00000000 000000e8 00008532 00000010
000000ea 40b50533 00000000 000000ee 00000001 00000010
000000f0 00c58593 00000000 0000008e 00308193 00000003
00000092 00418213 00000003 00000096 00000001 00000013
00000098 00520293 00000003 0000009c 00004605 00000013

/* compile.f */
logic/if_pkg.sv
logic/instr_bus_if.sv
logic/prefetch_unit.sv
logic/instr_aligner.sv
logic/if_stage.sv
logic/if_top.sv
dv/if_stage_checker.sv
dv/if_tb.sv

/* dv/if_tb.sv */
// Testbench for the fetch top level with a random-latency instruction memory and scripted control
`timescale 1ns/1ps

module if_tb;

  // Word offsets of the sections in the stimulus image
  localparam int STIM_WORDS = 256;
  localparam int MEM_OFS    = 'h10;
  localparam int CMD_OFS    = 'h40;
  localparam int EXP_OFS    = 'h80;

  // Command kinds as coded in the data file
  localparam int CMD_REDIRECT = 1;
  localparam int CMD_HALT     = 2;
  localparam int CMD_KILL     = 3;

  logic        clk;
  logic        rst_n;
  logic        pc_set;
  logic [1:0]  pc_mux;
  logic [31:0] pc_target;
  logic [1:0]  priv_lvl;
  logic        halt_if;
  logic        kill_if;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        if_valid;
  logic        if_ready;
  logic [31:0] id_pc;
  logic [31:0] id_instr;
  logic        id_compressed;
  logic [1:0]  id_priv_lvl;
  logic        id_ready;

  // Header words are base address, memory words, command count and expected count
  logic [31:0] stim [STIM_WORDS];
  // Addresses granted but not yet answered, oldest first
  logic [31:0] pending_addr [$];
  integer      seed;
  int          gnt_wait;
  logic        new_delay;
  int          retired;
  int          err_cnt;
  int          checker_errs;
  int          cmd_idx;

  if_top #(
    .FIFO_DEPTH (2)
  ) if_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set),
    .pc_mux_i        (pc_mux),
    .pc_target_i     (pc_target),
    .priv_lvl_i      (priv_lvl),
    .halt_if_i       (halt_if),
    .kill_if_i       (kill_if),
    .instr_req_o     (instr_req),
    .instr_addr_o    (instr_addr),
    .instr_gnt_i     (instr_gnt),
    .instr_rvalid_i  (instr_rvalid),
    .instr_rdata_i   (instr_rdata),
    .if_valid_o      (if_valid),
    .if_ready_o      (if_ready),
    .id_pc_o         (id_pc),
    .id_instr_o      (id_instr),
    .id_compressed_o (id_compressed),
    .id_priv_lvl_o   (id_priv_lvl),
    .id_ready_i      (id_ready)
  );

  if_stage_checker if_stage_checker_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .halt_if_i       (halt_if),
    .kill_if_i       (kill_if),
    .instr_req_i     (instr_req),
    .instr_gnt_i     (instr_gnt),
    .instr_addr_i    (instr_addr),
    .if_valid_i      (if_valid),
    .if_ready_i      (if_ready),
    .id_ready_i      (id_ready),
    .id_pc_i         (id_pc),
    .id_instr_i      (id_instr),
    .id_compressed_i (id_compressed),
    .id_priv_lvl_i   (id_priv_lvl),
    .error_count_o   (checker_errs)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////////////////////

  // Image words inside the loaded range, an address-derived pattern elsewhere
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - stim[0]) >> 2;
    if (addr >= stim[0] && idx < stim[1]) begin
      return stim[MEM_OFS + idx];
    end
    return ~addr;
  endfunction

  // Grant after 0 to 3 waiting cycles, answer in order with random gaps
  task automatic drive_bus();
    if (new_delay) begin
      gnt_wait  = $random(seed) & 3;
      new_delay = 1'b0;
    end
    instr_gnt = (gnt_wait == 0);
    if (pending_addr.size() > 0 && ($random(seed) & 3) != 0) begin
      instr_rvalid = 1'b1;
      instr_rdata  = read_word(pending_addr.pop_front());
    end else begin
      instr_rvalid = 1'b0;
      instr_rdata  = '0;
    end
  endtask

  // One falling edge with fresh bus responses and a random ID ready
  task automatic step();
    @(negedge clk);
    drive_bus();
    id_ready = ($random(seed) & 3) != 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Retirement check against the expected stream
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_retire();
    int          ofs;
    logic [31:0] flags;
    ofs   = EXP_OFS + 3 * retired;
    flags = stim[ofs + 2];
    if (retired >= stim[3]) begin
      $display("An instruction at pc 0x%08h retired after the expected stream ended", id_pc);
      err_cnt++;
    end else begin
      if (id_pc !== stim[ofs]) begin
        $display("Error: id_pc_o = 0x%08h, expected 0x%08h at instruction %0d",
                 id_pc, stim[ofs], retired);
        err_cnt++;
      end
      if (id_instr !== stim[ofs + 1]) begin
        $display("Error: id_instr_o = 0x%08h, expected 0x%08h at instruction %0d",
                 id_instr, stim[ofs + 1], retired);
        err_cnt++;
      end
      // Bit 4 of the flags word is the compressed flag, bits 1:0 the privilege
      if (id_compressed !== flags[4]) begin
        $display("Error: id_compressed_o = 0x%h, expected 0x%h at instruction %0d",
                 id_compressed, flags[4], retired);
        err_cnt++;
      end
      if (id_priv_lvl !== flags[1:0]) begin
        $display("Error: id_priv_lvl_o = 0x%h, expected 0x%h at instruction %0d",
                 id_priv_lvl, flags[1:0], retired);
        err_cnt++;
      end
    end
    retired++;
  endtask

  // Grants and retirements are taken at the rising edge before the DUT updates
  always @(posedge clk) begin
    if (rst_n) begin
      if (instr_req && instr_gnt) begin
        pending_addr.push_back(instr_addr);
        new_delay = 1'b1;
      end else if (instr_req && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
      if (if_valid && id_ready) begin
        check_retire();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Controller commands
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_command(input int idx);
    int          ofs;
    logic [31:0] kind;
    logic [31:0] arg;
    ofs  = CMD_OFS + 4 * idx;
    kind = stim[ofs + 1];
    arg  = stim[ofs + 2];
    if (kind == CMD_REDIRECT) begin
      // The controller kills the old stream in the same cycle as the PC set
      pc_set    = 1'b1;
      kill_if   = 1'b1;
      pc_mux    = if_pkg::PC_JUMP;
      pc_target = arg;
      priv_lvl  = stim[ofs + 3][1:0];
      step();
      pc_set  = 1'b0;
      kill_if = 1'b0;
    end else if (kind == CMD_HALT) begin
      halt_if = 1'b1;
      repeat (arg) step();
      halt_if = 1'b0;
    end else if (kind == CMD_KILL) begin
      kill_if = 1'b1;
      repeat (arg) step();
      kill_if = 1'b0;
    end else begin
      $display("The stimulus file holds an unknown command kind %0d", kind);
      err_cnt++;
    end
  endtask

  initial begin
    seed         = 32'he0f5b551;
    rst_n        = 1'b0;
    pc_set       = 1'b0;
    pc_mux       = if_pkg::PC_BOOT;
    pc_target    = '0;
    priv_lvl     = if_pkg::PRIV_LVL_M;
    halt_if      = 1'b0;
    kill_if      = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    id_ready     = 1'b0;
    gnt_wait     = 0;
    new_delay    = 1'b1;
    retired      = 0;
    err_cnt      = 0;
    cmd_idx      = 0;
    $readmemh("dv/if_stim.txt", stim);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // Commands fire once the retired count reaches their trigger
    while (retired < stim[3]) begin
      step();
      if (cmd_idx < stim[2] && retired == stim[CMD_OFS + 4 * cmd_idx]) begin
        apply_command(cmd_idx);
        cmd_idx++;
      end
    end
    id_ready = 1'b0;
    repeat (4) @(negedge clk);
    $display("Errors: %0d in the retired stream, %0d from the checker, %0d of %0d retired",
             err_cnt, checker_errs, retired, stim[3]);
    if (err_cnt == 0 && checker_errs == 0 && retired == stim[3]) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Forty cycles per expected instruction on top of reset and a fixed margin
  initial begin : watchdog
    int limit;
    #1;
    limit = 16 + stim[3] * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout with only %0d of %0d instructions retired", retired, stim[3]);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* dv/if_stage_checker.sv */
// Monitor of the instruction bus handshake and the IF/ID handshake rules at the top-level ports
`timescale 1ns/1ps

module if_stage_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        halt_if_i,
  input  logic        kill_if_i,
  input  logic        instr_req_i,
  input  logic        instr_gnt_i,
  input  logic [31:0] instr_addr_i,
  input  logic        if_valid_i,
  input  logic        if_ready_i,
  input  logic        id_ready_i,
  input  logic [31:0] id_pc_i,
  input  logic [31:0] id_instr_i,
  input  logic        id_compressed_i,
  input  logic [1:0]  id_priv_lvl_i,
  output int          error_count_o
);

  // Request left waiting for its grant in the previous cycle
  logic        wait_gnt_q;
  logic [31:0] wait_addr_q;
  // IF/ID outputs as seen in a cycle stalled by the ID stage
  logic        stall_q;
  logic [31:0] held_pc_q;
  logic [31:0] held_instr_q;
  logic        held_compr_q;
  logic [1:0]  held_priv_q;

  initial error_count_o = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction bus rules
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      if (instr_req_i !== 1'b0) begin
        $display("Error: instr_req_o = 0x%h during reset, expected 0x0", instr_req_i);
        error_count_o++;
      end
      wait_gnt_q <= 1'b0;
    end else begin
      if (instr_req_i && instr_addr_i[1:0] != 2'b00) begin
        $display("Error: instr_addr_o = 0x%08h is not word aligned", instr_addr_i);
        error_count_o++;
      end
      // Once raised, a request holds with the same address until granted
      if (wait_gnt_q && !instr_req_i) begin
        $display("The instruction request dropped before it was granted");
        error_count_o++;
      end
      if (wait_gnt_q && instr_req_i && instr_addr_i !== wait_addr_q) begin
        $display("Error: instr_addr_o = 0x%08h, expected 0x%08h while waiting for grant",
                 instr_addr_i, wait_addr_q);
        error_count_o++;
      end
      wait_gnt_q  <= instr_req_i && !instr_gnt_i;
      wait_addr_q <= instr_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID handshake rules
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      if (if_valid_i !== 1'b0) begin
        $display("Error: if_valid_o = 0x%h during reset, expected 0x0", if_valid_i);
        error_count_o++;
      end
      stall_q <= 1'b0;
    end else begin
      // Kill drains the stage and wins over halt
      if (kill_if_i) begin
        if (if_valid_i !== 1'b0) begin
          $display("Error: if_valid_o = 0x%h under kill, expected 0x0", if_valid_i);
          error_count_o++;
        end
        if (if_ready_i !== 1'b1) begin
          $display("Error: if_ready_o = 0x%h under kill, expected 0x1", if_ready_i);
          error_count_o++;
        end
      end else if (halt_if_i) begin
        if (if_valid_i !== 1'b0) begin
          $display("Error: if_valid_o = 0x%h under halt, expected 0x0", if_valid_i);
          error_count_o++;
        end
        if (if_ready_i !== 1'b0) begin
          $display("Error: if_ready_o = 0x%h under halt, expected 0x0", if_ready_i);
          error_count_o++;
        end
      end
      // An offered instruction that was not taken stays as it was
      if (stall_q && !kill_if_i) begin
        if (!halt_if_i && if_valid_i !== 1'b1) begin
          $display("Error: if_valid_o = 0x%h after a stall, expected 0x1", if_valid_i);
          error_count_o++;
        end
        if (id_pc_i !== held_pc_q) begin
          $display("Error: id_pc_o = 0x%08h, expected 0x%08h under back-pressure",
                   id_pc_i, held_pc_q);
          error_count_o++;
        end
        if (id_instr_i !== held_instr_q) begin
          $display("Error: id_instr_o = 0x%08h, expected 0x%08h under back-pressure",
                   id_instr_i, held_instr_q);
          error_count_o++;
        end
        if (id_compressed_i !== held_compr_q || id_priv_lvl_i !== held_priv_q) begin
          $display("Error: id_compressed_o = 0x%h id_priv_lvl_o = 0x%h, expected 0x%h 0x%h",
                   id_compressed_i, id_priv_lvl_i, held_compr_q, held_priv_q);
          error_count_o++;
        end
      end
      stall_q      <= if_valid_i && !id_ready_i;
      held_pc_q    <= id_pc_i;
      held_instr_q <= id_instr_i;
      held_compr_q <= id_compressed_i;
      held_priv_q  <= id_priv_lvl_i;
    end
  end

endmodule

/* logic/if_top.sv */
// Fetch top level that ties prefetch, aligner and IF stage to plain bus and ID ports
`timescale 1ns/1ps

module if_top #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  // Controller side
  input  logic        pc_set_i,
  input  logic [1:0]  pc_mux_i,
  input  logic [31:0] pc_target_i,
  input  logic [1:0]  priv_lvl_i,
  input  logic        halt_if_i,
  input  logic        kill_if_i,
  // Instruction bus
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  // ID side
  output logic        if_valid_o,
  output logic        if_ready_o,
  output logic [31:0] id_pc_o,
  output logic [31:0] id_instr_o,
  output logic        id_compressed_o,
  output logic [1:0]  id_priv_lvl_o,
  input  logic        id_ready_i
);

  if_pkg::ctrl_fsm_t   ctrl_fsm;
  if_pkg::if_id_pipe_t aligned_instr;
  if_pkg::if_id_pipe_t if_id_pipe;
  logic                fetch_valid;
  logic                fetch_ready;
  logic [31:0]         fetch_word;
  logic                instr_valid;
  logic                instr_ready;

  instr_bus_if instr_bus ();

  // Control word assembled from the plain inputs
  assign ctrl_fsm.pc_set    = pc_set_i;
  assign ctrl_fsm.pc_mux    = if_pkg::pc_mux_e'(pc_mux_i);
  assign ctrl_fsm.pc_target = pc_target_i;
  assign ctrl_fsm.priv_lvl  = if_pkg::privlvl_e'(priv_lvl_i);
  assign ctrl_fsm.halt_if   = halt_if_i;
  assign ctrl_fsm.kill_if   = kill_if_i;

  // Bus interface to and from the pins
  assign instr_req_o      = instr_bus.req;
  assign instr_addr_o     = instr_bus.addr;
  assign instr_bus.gnt    = instr_gnt_i;
  assign instr_bus.rvalid = instr_rvalid_i;
  assign instr_bus.rdata  = instr_rdata_i;

  prefetch_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (ctrl_fsm.pc_set),
    .pc_target_i   (ctrl_fsm.pc_target),
    .bus_m         (instr_bus.manager),
    .fetch_valid_o (fetch_valid),
    .fetch_word_o  (fetch_word),
    .fetch_ready_i (fetch_ready)
  );

  instr_aligner instr_aligner_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (ctrl_fsm.pc_set),
    .pc_target_i   (ctrl_fsm.pc_target),
    .fetch_valid_i (fetch_valid),
    .fetch_word_i  (fetch_word),
    .fetch_ready_o (fetch_ready),
    .instr_valid_o (instr_valid),
    .instr_o       (aligned_instr),
    .instr_ready_i (instr_ready)
  );

  if_stage if_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_fsm_i    (ctrl_fsm),
    .instr_valid_i (instr_valid),
    .instr_i       (aligned_instr),
    .instr_ready_o (instr_ready),
    .if_valid_o    (if_valid_o),
    .if_ready_o    (if_ready_o),
    .id_ready_i    (id_ready_i),
    .if_id_pipe_o  (if_id_pipe)
  );

  // ID side fields straight from the IF/ID register
  assign id_pc_o         = if_id_pipe.pc;
  assign id_instr_o      = if_id_pipe.instr;
  assign id_compressed_o = if_id_pipe.compressed;
  assign id_priv_lvl_o   = if_id_pipe.priv_lvl;

endmodule

/* logic/if_stage.sv */
// IF stage that applies halt and kill, stamps privilege and holds the IF/ID register
`timescale 1ns/1ps

module if_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                instr_valid_i,
  input  if_pkg::if_id_pipe_t instr_i,
  output logic                instr_ready_o,
  output logic                if_valid_o,
  output logic                if_ready_o,
  input  logic                id_ready_i,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);

  if_pkg::privlvl_e    priv_q;
  logic                killed_q;
  logic                kill_eff;
  logic                pipe_valid_q;
  if_pkg::if_id_pipe_t pipe_q;
  logic                load;
  logic                advance;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////////////////////

  // After a kill the old stream stays dead until the controller redirects
  assign kill_eff = ctrl_fsm_i.kill_if || killed_q;

  // Kill drains everything and wins over halt, halt freezes both directions
  assign if_valid_o = pipe_valid_q && !kill_eff && !ctrl_fsm_i.halt_if;
  assign if_ready_o = kill_eff ||
                      (!ctrl_fsm_i.halt_if && (!pipe_valid_q || id_ready_i));
  assign advance    = if_valid_o && id_ready_i;

  // The aligner sees the same ready, so killed instructions are consumed
  assign instr_ready_o = if_ready_o;
  assign load          = instr_valid_i && if_ready_o && !kill_eff;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      killed_q <= 1'b0;
    end else if (ctrl_fsm_i.pc_set) begin
      killed_q <= 1'b0;
    end else if (ctrl_fsm_i.kill_if) begin
      killed_q <= 1'b1;
    end
  end

  // Privilege of the new stream comes with the redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_q <= if_pkg::PRIV_LVL_M;
    end else if (ctrl_fsm_i.pc_set) begin
      priv_q <= ctrl_fsm_i.priv_lvl;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_q <= 1'b0;
    end else if (kill_eff) begin
      pipe_valid_q <= 1'b0;
    end else if (load) begin
      pipe_valid_q <= 1'b1;
    end else if (advance) begin
      pipe_valid_q <= 1'b0;
    end
  end

  // Payload only moves on a load, so it stays put under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      pipe_q          <= instr_i;
      pipe_q.priv_lvl <= priv_q;
    end
  end

  always_comb begin
    if_id_pipe_o             = pipe_q;
    if_id_pipe_o.instr_valid = pipe_valid_q;
  end

endmodule

/* logic/instr_aligner.sv */
// Instruction aligner that cuts 16- and 32-bit instructions out of the fetched word stream
`timescale 1ns/1ps

module instr_aligner (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pc_set_i,
  input  logic [31:0]        pc_target_i,
  input  logic               fetch_valid_i,
  input  logic [31:0]        fetch_word_i,
  output logic               fetch_ready_o,
  output logic               instr_valid_o,
  output if_pkg::if_id_pipe_t instr_o,
  input  logic               instr_ready_i
);

  logic [31:0] pc_q;
  logic [15:0] resid_q;
  logic        resid_valid_q;
  logic        skip_low_q;
  logic [31:0] instr_bits;
  logic        valid_raw;
  logic        take_word;
  logic        park_word;
  logic        is_compr;
  logic        instr_fire;
  logic        word_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction selection
  ////////////////////////////////////////////////////////////////////////////

  // Three sources, in priority order: a parked upper halfword, the upper half
  // of a word entered at an odd halfword target, or a fresh word
  always_comb begin
    instr_bits = fetch_word_i;
    valid_raw  = 1'b0;
    take_word  = 1'b0;
    park_word  = 1'b0;
    if (resid_valid_q) begin
      if (resid_q[1:0] != 2'b11) begin
        // Compressed instruction fully held in the residue
        instr_bits = {16'h0000, resid_q};
        valid_raw  = 1'b1;
      end else begin
        // 32-bit instruction crossing a word, low part from the residue
        instr_bits = {fetch_word_i[15:0], resid_q};
        valid_raw  = fetch_valid_i;
        take_word  = 1'b1;
      end
    end else if (skip_low_q) begin
      if (fetch_word_i[17:16] != 2'b11) begin
        instr_bits = {16'h0000, fetch_word_i[31:16]};
        valid_raw  = fetch_valid_i;
        take_word  = 1'b1;
      end else begin
        // Upper half starts a 32-bit instruction, so park it and wait
        park_word = 1'b1;
      end
    end else begin
      if (fetch_word_i[1:0] != 2'b11) begin
        instr_bits = {16'h0000, fetch_word_i[15:0]};
      end
      valid_raw = fetch_valid_i;
      take_word = 1'b1;
    end
  end

  assign is_compr = instr_bits[1:0] != 2'b11;

  // Nothing leaves and nothing is taken in the flush cycle
  assign instr_valid_o = valid_raw && !pc_set_i;
  assign instr_fire    = instr_valid_o && instr_ready_i;
  assign fetch_ready_o = !pc_set_i && (park_word || (take_word && instr_ready_i));
  assign word_fire     = fetch_valid_i && fetch_ready_o;

  // Privilege is stamped by the IF stage when the instruction is registered
  assign instr_o.instr_valid = instr_valid_o;
  assign instr_o.pc          = pc_q;
  assign instr_o.instr       = instr_bits;
  assign instr_o.compressed  = is_compr;
  assign instr_o.priv_lvl    = if_pkg::PRIV_LVL_M;

  ////////////////////////////////////////////////////////////////////////////
  // PC and residue state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= if_pkg::RESET_PC;
      resid_q       <= '0;
      resid_valid_q <= 1'b0;
      skip_low_q    <= if_pkg::RESET_PC[1];
    end else if (pc_set_i) begin
      // Target at an odd halfword skips the low half of its first word
      pc_q          <= pc_target_i;
      resid_valid_q <= 1'b0;
      skip_low_q    <= pc_target_i[1];
    end else begin
      if (instr_fire) begin
        pc_q <= pc_q + (is_compr ? 32'd2 : 32'd4);
      end
      if (word_fire) begin
        skip_low_q <= 1'b0;
      end
      if (resid_valid_q) begin
        if (instr_fire) begin
          if (is_compr) begin
            resid_valid_q <= 1'b0;
          end else begin
            // Crossing instruction done, upper half of the new word remains
            resid_q <= fetch_word_i[31:16];
          end
        end
      end else if (word_fire) begin
        if (park_word || (!skip_low_q && is_compr)) begin
          resid_valid_q <= 1'b1;
          resid_q       <= fetch_word_i[31:16];
        end
      end
    end
  end

endmodule

/* logic/prefetch_unit.sv */
// Prefetch unit that issues word fetches and buffers the responses in a flushable FIFO
`timescale 1ns/1ps

module prefetch_unit #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         pc_set_i,
  input  logic [31:0]  pc_target_i,
  instr_bus_if.manager bus_m,
  output logic         fetch_valid_o,
  output logic [31:0]  fetch_word_o,
  input  logic         fetch_ready_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  // Outstanding counters get two spare bits since stale responses can pile up
  // behind live ones when redirects come in quick succession
  localparam int OUT_W = CNT_W + 2;

  logic [31:0]      fetch_addr_q;
  logic [31:0]      target_word;
  logic             pending_q;
  logic             redir_q;
  logic [31:0]      redir_addr_q;
  logic [OUT_W-1:0] out_cnt_q;
  logic [OUT_W-1:0] out_cnt_d;
  logic [OUT_W-1:0] discard_cnt_q;
  logic [OUT_W-1:0] discard_cnt_d;
  logic [OUT_W-1:0] occupancy;
  logic             room;
  logic             grant;
  logic             resp_drop;
  logic             push;
  logic             pop;
  logic [31:0]      fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fifo_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // The bus only ever sees word addresses
  assign target_word = {pc_target_i[31:2], 2'b00};

  // Words already buffered plus live requests in flight must fit the FIFO
  assign occupancy = OUT_W'(fifo_cnt_q) + out_cnt_q - discard_cnt_q;
  assign room      = occupancy < OUT_W'(FIFO_DEPTH);

  // A request that was not granted stays up with the same address
  // A fresh request waits one cycle after a redirect
  // Nothing is requested while reset is held
  assign bus_m.req  = rst_n && (pending_q || (room && !pc_set_i));
  assign bus_m.addr = fetch_addr_q;
  assign grant      = bus_m.req && bus_m.gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= {if_pkg::RESET_PC[31:2], 2'b00};
      pending_q    <= 1'b0;
      redir_q      <= 1'b0;
      redir_addr_q <= '0;
    end else begin
      pending_q <= bus_m.req && !bus_m.gnt;
      if (pc_set_i) begin
        if (bus_m.req && !bus_m.gnt) begin
          // Cannot move the address under a waiting request, so remember the
          // target and apply it once the stale request is granted
          redir_q      <= 1'b1;
          redir_addr_q <= target_word;
        end else begin
          redir_q      <= 1'b0;
          fetch_addr_q <= target_word;
        end
      end else if (grant) begin
        if (redir_q) begin
          redir_q      <= 1'b0;
          fetch_addr_q <= redir_addr_q;
        end else begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding and discard tracking
  ////////////////////////////////////////////////////////////////////////////

  // Responses are dropped while stale ones are still due, or in the flush cycle
  assign resp_drop = pc_set_i || (discard_cnt_q != '0);

  always_comb begin
    out_cnt_d     = out_cnt_q + OUT_W'(grant) - OUT_W'(bus_m.rvalid);
    discard_cnt_d = discard_cnt_q;
    if (pc_set_i) begin
      // Everything still on the bus belongs to the old stream
      discard_cnt_d = out_cnt_d;
    end else begin
      if (bus_m.rvalid && (discard_cnt_q != '0)) begin
        discard_cnt_d = discard_cnt_d - OUT_W'(1);
      end
      // The held request that outlived a redirect is stale as well
      if (grant && redir_q) begin
        discard_cnt_d = discard_cnt_d + OUT_W'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
    end else begin
      out_cnt_q     <= out_cnt_d;
      discard_cnt_q <= discard_cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response FIFO
  ////////////////////////////////////////////////////////////////////////////

  assign push          = bus_m.rvalid && !resp_drop;
  assign pop           = fetch_valid_o && fetch_ready_i && !pc_set_i;
  assign fetch_valid_o = fifo_cnt_q != '0;
  assign fetch_word_o  = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (pc_set_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Storage only, the pointers say what is valid
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= bus_m.rdata;
    end
  end

endmodule

/* logic/instr_bus_if.sv */
// Instruction bus with request/grant address phase and in-order response phase
`timescale 1ns/1ps

interface instr_bus_if;

  // Address phase, accepted in a cycle where req and gnt are both high
  logic        req;
  logic        gnt;
  logic [31:0] addr;

  // Response phase, one beat per granted request and in request order
  logic        rvalid;
  logic [31:0] rdata;

  // The fetch side drives the address phase and samples the rest
  modport manager (
    output req,
    output addr,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  // Passive view for anything that only watches the bus
  modport monitor (
    input req,
    input gnt,
    input addr,
    input rvalid,
    input rdata
  );

endinterface

/* logic/if_pkg.sv */
// IF stage package with privilege, PC source and control types and the IF/ID pipe record
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////////////////////////////////////////

  // Privilege levels use the RISC-V encoding, so user and machine keep their
  // architectural values when they reach CSR logic further down the pipe
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_e;

  // Source of a PC set as chosen by the controller
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_TRAP = 2'b10,
    PC_MRET = 2'b11
  } pc_mux_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structures
  ////////////////////////////////////////////////////////////////////////////

  // Control word from the controller FSM to the fetch side
  typedef struct packed {
    logic        pc_set;
    pc_mux_e     pc_mux;
    logic [31:0] pc_target;
    privlvl_e    priv_lvl;
    logic        halt_if;
    logic        kill_if;
  } ctrl_fsm_t;

  // One instruction as it travels from IF to ID
  // Compressed instructions carry zeros in the upper halfword
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    privlvl_e    priv_lvl;
  } if_id_pipe_t;

  // First fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0000_0080;

endpackage
